/* udp_tx_pkg.sv */
`default_nettype none

package udp_tx_pkg;

  // Data path and field widths
  localparam int WORD_W = 64;
  localparam int MAC_W  = 48;
  localparam int IP_W   = 32;
  localparam int PORT_W = 16;
  localparam int LEN_W  = 16;  // Word count and IP/UDP lengths
  localparam int ARP_AW = 8;   // 256 ARP entries

  // Protocol constants
  localparam logic [15:0] ETHERTYPE_IPV4   = 16'h0800;
  localparam logic [7:0]  IP_VER_IHL       = 8'h45;
  localparam logic [15:0] IP_FLAGS_FRAG    = 16'h4000;  // Don't fragment
  localparam logic [7:0]  IP_PROTO_UDP     = 8'h11;
  localparam logic [23:0] MCAST_MAC_PREFIX = 24'h01005E;

  localparam int IP_UDP_HDR_BYTES = 28;
  localparam int UDP_HDR_BYTES    = 8;

  // Descriptor FIFO word, stored raw and decoded as fields
  typedef union packed {
    logic [WORD_W-1:0] raw;
    struct packed {
      logic [LEN_W-1:0]  word_count;
      logic [PORT_W-1:0] dest_port;
      logic [IP_W-1:0]   dest_ip;
    } fields;
  } ctrl_word_u;

endpackage

`default_nettype wire

/* sync_fifo.sv */
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 64,
  parameter int DEPTH = 16
) (
  input  logic             mac_clk,
  input  logic             app_rst,
  input  logic             push,
  input  logic [WIDTH-1:0] wdata,
  output logic             full,
  input  logic             pop,
  output logic [WIDTH-1:0] rdata,
  output logic             empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             do_push;
  logic             do_pop;

  // Wrap also for depths that are not a power of two
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign full    = (count == CW'(DEPTH));
  assign empty   = (count == '0);
  assign rdata   = mem[rd_ptr];  // Head word always visible

  always_ff @(posedge mac_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* udp_tx_ingress.sv */
`default_nettype none

module udp_tx_ingress import udp_tx_pkg::*; (
  input  logic              mac_clk,
  input  logic              app_rst,
  // Application side
  input  logic              app_tx_valid,
  output logic              app_tx_ready,
  input  logic [WORD_W-1:0] app_tx_data,
  input  logic              app_tx_end_of_frame,
  input  logic [IP_W-1:0]   app_tx_dest_ip,
  input  logic [PORT_W-1:0] app_tx_dest_port,
  // Payload FIFO write side
  output logic              data_push,
  output logic [WORD_W-1:0] data_wdata,
  input  logic              data_full,
  // Descriptor FIFO write side
  output logic              ctrl_push,
  output ctrl_word_u        ctrl_wdata,
  input  logic              ctrl_full
);

  logic [LEN_W-1:0] word_count;  // Includes the word on the current beat
  logic             accept;

  // Both FIFOs need room so a frame and its descriptor always fit
  assign app_tx_ready = !data_full && !ctrl_full;
  assign accept       = app_tx_valid && app_tx_ready;

  assign data_push  = accept;
  assign data_wdata = app_tx_data;

  // Descriptor lands on the same edge as the last payload word
  assign ctrl_push = accept && app_tx_end_of_frame;

  always_comb begin
    ctrl_wdata.fields.word_count = word_count;
    ctrl_wdata.fields.dest_port  = app_tx_dest_port;
    ctrl_wdata.fields.dest_ip    = app_tx_dest_ip;
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      word_count <= LEN_W'(1);
    end else if (accept) begin
      if (app_tx_end_of_frame) begin
        word_count <= LEN_W'(1);  // Next frame starts over
      end else begin
        word_count <= word_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* arp_table.sv */
`default_nettype none

module arp_table import udp_tx_pkg::*; (
  input  logic              mac_clk,
  // Host access
  input  logic [ARP_AW-1:0] arp_addr,
  input  logic              arp_wr_en,
  input  logic [MAC_W-1:0]  arp_wr_data,
  output logic [MAC_W-1:0]  arp_rd_data,
  // Framer lookup
  input  logic [IP_W-1:0]   local_ip,
  input  logic [ARP_AW-1:0] local_gateway,
  input  logic [IP_W-1:0]   dest_ip,
  output logic [MAC_W-1:0]  dest_mac
);

  logic [MAC_W-1:0]  cache [2**ARP_AW];
  logic              on_subnet;
  logic [ARP_AW-1:0] hop_addr;

  // Same /24 goes direct, anything else via the gateway
  assign on_subnet = (dest_ip[IP_W-1:8] == local_ip[IP_W-1:8]);
  assign hop_addr  = on_subnet ? dest_ip[ARP_AW-1:0] : local_gateway;

  always_ff @(posedge mac_clk) begin
    if (arp_wr_en) begin
      cache[arp_addr] <= arp_wr_data;
    end
    arp_rd_data <= cache[arp_addr];
  end

  always_ff @(posedge mac_clk) begin
    dest_mac <= cache[hop_addr];  // One cycle after the IP
  end

endmodule

`default_nettype wire

/* ip_header_calc.sv */
`default_nettype none

module ip_header_calc import udp_tx_pkg::*; #(
  parameter logic [7:0] TTL = 8'h40
) (
  input  logic              mac_clk,
  input  logic              app_rst,
  input  logic              load,
  input  logic [LEN_W-1:0]  word_count,
  input  logic [IP_W-1:0]   dest_ip,
  input  logic [IP_W-1:0]   local_ip,
  output logic [LEN_W-1:0]  ip_length,
  output logic [LEN_W-1:0]  udp_length,
  output logic [15:0]       ip_checksum,
  output logic              hdr_valid
);

  logic [IP_W-1:0] src_ip_r;
  logic [IP_W-1:0] dst_ip_r;
  logic [19:0]     sum_r;    // Nine halfwords need 20 bits
  logic [16:0]     fold_r;
  logic [2:0]      stage;

  // Stage 1 latches the descriptor and forms the lengths
  always_ff @(posedge mac_clk) begin
    if (load) begin
      src_ip_r   <= local_ip;
      dst_ip_r   <= dest_ip;
      ip_length  <= (word_count << 3) + LEN_W'(IP_UDP_HDR_BYTES);
      udp_length <= (word_count << 3) + LEN_W'(UDP_HDR_BYTES);
    end
  end

  // Checksum with the checksum field itself taken as zero
  always_ff @(posedge mac_clk) begin
    sum_r <= 20'({IP_VER_IHL, 8'h00}) + 20'(ip_length) + 20'(16'h0000)
           + 20'(IP_FLAGS_FRAG) + 20'({TTL, IP_PROTO_UDP})
           + 20'(src_ip_r[31:16]) + 20'(src_ip_r[15:0])
           + 20'(dst_ip_r[31:16]) + 20'(dst_ip_r[15:0]);
    fold_r      <= 17'(sum_r[15:0]) + 17'(sum_r[19:16]);
    ip_checksum <= ~(fold_r[15:0] + 16'(fold_r[16]));  // Second fold
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      stage     <= '0;
      hdr_valid <= 1'b0;
    end else begin
      stage <= {stage[1:0], load};
      if (load) begin
        hdr_valid <= 1'b0;
      end else if (stage[2]) begin
        hdr_valid <= 1'b1;  // Held until the next load
      end
    end
  end

endmodule

`default_nettype wire

/* udp_frame_tx.sv */
`default_nettype none

module udp_frame_tx import udp_tx_pkg::*; #(
  parameter logic [7:0] TTL = 8'h40
) (
  input  logic              mac_clk,
  input  logic              app_rst,
  input  logic              local_enable,
  input  logic [MAC_W-1:0]  local_mac,
  input  logic [IP_W-1:0]   local_ip,
  input  logic [PORT_W-1:0] local_port,
  // Descriptor and payload FIFO heads
  input  ctrl_word_u        ctrl_rdata,
  input  logic              ctrl_empty,
  output logic              ctrl_pop,
  input  logic [WORD_W-1:0] data_rdata,
  output logic              data_pop,
  // Header calculator and ARP lookup
  output logic              hdr_load,
  input  logic              hdr_valid,
  input  logic [LEN_W-1:0]  ip_length,
  input  logic [LEN_W-1:0]  udp_length,
  input  logic [15:0]       ip_checksum,
  input  logic [MAC_W-1:0]  dest_mac,
  // MAC side
  output logic              mac_tx_start,
  input  logic              mac_tx_ack,
  output logic [WORD_W-1:0] mac_tx_data,
  output logic [7:0]        mac_tx_data_valid
);

  localparam logic [3:0] ST_IDLE     = 4'd0;
  localparam logic [3:0] ST_HDR_WAIT = 4'd1;
  localparam logic [3:0] ST_HDR1     = 4'd2;
  localparam logic [3:0] ST_HDR1_MC  = 4'd3;
  localparam logic [3:0] ST_HDR2     = 4'd4;
  localparam logic [3:0] ST_HDR3     = 4'd5;
  localparam logic [3:0] ST_HDR4     = 4'd6;
  localparam logic [3:0] ST_HDR5     = 4'd7;
  localparam logic [3:0] ST_HDR6     = 4'd8;
  localparam logic [3:0] ST_DATA     = 4'd9;
  localparam logic [3:0] ST_LAST     = 4'd10;

  logic [3:0]        state;
  logic [LEN_W-1:0]  words_left;
  logic [15:0]       leftover;    // Last two bytes of the previous payload word
  logic [MAC_W-1:0]  mcast_mac;
  logic              is_mcast;
  logic [WORD_W-1:0] frame_word;  // First wire byte in the top bits

  // Reverse bytes so the first wire byte lands in lane 0
  function automatic logic [WORD_W-1:0] to_lanes(input logic [WORD_W-1:0] w);
    logic [WORD_W-1:0] r;
    for (int i = 0; i < WORD_W / 8; i++) begin
      r[8*i +: 8] = w[WORD_W-8-8*i +: 8];
    end
    return r;
  endfunction

  assign is_mcast  = (ctrl_rdata.fields.dest_ip[31:28] == 4'hE);
  assign mcast_mac = {MCAST_MAC_PREFIX, 1'b0, ctrl_rdata.fields.dest_ip[22:0]};

  assign hdr_load     = (state == ST_IDLE) && !ctrl_empty && local_enable;
  assign mac_tx_start = (state == ST_HDR1) || (state == ST_HDR1_MC);
  assign data_pop     = (state == ST_HDR6) || (state == ST_DATA);
  assign ctrl_pop     = (state == ST_LAST);  // Descriptor leaves with the frame

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      state      <= ST_IDLE;
      words_left <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (hdr_load) begin
            state      <= ST_HDR_WAIT;
            words_left <= ctrl_rdata.fields.word_count - 1'b1;
          end
        end
        ST_HDR_WAIT: begin
          if (hdr_valid) state <= is_mcast ? ST_HDR1_MC : ST_HDR1;
        end
        ST_HDR1, ST_HDR1_MC: begin
          if (mac_tx_ack) state <= ST_HDR2;  // First word held until ack
        end
        ST_HDR2: state <= ST_HDR3;
        ST_HDR3: state <= ST_HDR4;
        ST_HDR4: state <= ST_HDR5;
        ST_HDR5: state <= ST_HDR6;
        ST_HDR6, ST_DATA: begin
          words_left <= words_left - 1'b1;
          state      <= (words_left == '0) ? ST_LAST : ST_DATA;
        end
        default: state <= ST_IDLE;  // ST_LAST included
      endcase
    end
  end

  always_ff @(posedge mac_clk) begin
    if (data_pop) begin
      leftover <= data_rdata[15:0];
    end
  end

  // Header layout in wire order, 42 bytes before the payload
  always_comb begin
    frame_word        = '0;
    mac_tx_data_valid = 8'hFF;
    case (state)
      ST_HDR1:    frame_word = {dest_mac, local_mac[47:32]};
      ST_HDR1_MC: frame_word = {mcast_mac, local_mac[47:32]};
      ST_HDR2:    frame_word = {local_mac[31:0], ETHERTYPE_IPV4, IP_VER_IHL, 8'h00};
      ST_HDR3:    frame_word = {ip_length, 16'h0000, IP_FLAGS_FRAG, TTL, IP_PROTO_UDP};
      ST_HDR4: begin
        frame_word = {ip_checksum, local_ip, ctrl_rdata.fields.dest_ip[31:16]};
      end
      ST_HDR5: begin
        frame_word = {ctrl_rdata.fields.dest_ip[15:0], local_port,
                      ctrl_rdata.fields.dest_port, udp_length};
      end
      ST_HDR6:    frame_word = {16'h0000, data_rdata[63:16]};  // No UDP checksum
      ST_DATA:    frame_word = {leftover, data_rdata[63:16]};
      ST_LAST: begin
        frame_word        = {leftover, 48'h0};
        mac_tx_data_valid = 8'h03;
      end
      default:    mac_tx_data_valid = 8'h00;
    endcase
  end

  assign mac_tx_data = to_lanes(frame_word);

endmodule

`default_nettype wire

/* udp_tx_top.sv */
`default_nettype none

module udp_tx_top import udp_tx_pkg::*; #(
  parameter int         DATA_DEPTH = 512,
  parameter int         CTRL_DEPTH = 16,
  parameter logic [7:0] TTL        = 8'h40
) (
  input  logic              mac_clk,
  input  logic              app_rst,
  // Local configuration
  input  logic              local_enable,
  input  logic [MAC_W-1:0]  local_mac,
  input  logic [IP_W-1:0]   local_ip,
  input  logic [PORT_W-1:0] local_port,
  input  logic [ARP_AW-1:0] local_gateway,
  // ARP host port
  input  logic [ARP_AW-1:0] arp_addr,
  input  logic              arp_wr_en,
  input  logic [MAC_W-1:0]  arp_wr_data,
  output logic [MAC_W-1:0]  arp_rd_data,
  // Application
  input  logic              app_tx_valid,
  output logic              app_tx_ready,
  input  logic [WORD_W-1:0] app_tx_data,
  input  logic              app_tx_end_of_frame,
  input  logic [IP_W-1:0]   app_tx_dest_ip,
  input  logic [PORT_W-1:0] app_tx_dest_port,
  // MAC
  output logic              mac_tx_start,
  input  logic              mac_tx_ack,
  output logic [WORD_W-1:0] mac_tx_data,
  output logic [7:0]        mac_tx_data_valid
);

  logic              data_push;
  logic              data_full;
  logic              data_pop;
  logic [WORD_W-1:0] data_wdata;
  logic [WORD_W-1:0] data_rdata;
  logic              ctrl_push;
  logic              ctrl_full;
  logic              ctrl_pop;
  logic              ctrl_empty;
  ctrl_word_u        ctrl_wdata;
  ctrl_word_u        ctrl_rdata;
  logic              hdr_load;
  logic              hdr_valid;
  logic [LEN_W-1:0]  ip_length;
  logic [LEN_W-1:0]  udp_length;
  logic [15:0]       ip_checksum;
  logic [MAC_W-1:0]  dest_mac;

  udp_tx_ingress ingress0 (
    .mac_clk, .app_rst, .app_tx_valid, .app_tx_ready, .app_tx_data,
    .app_tx_end_of_frame, .app_tx_dest_ip, .app_tx_dest_port,
    .data_push, .data_wdata, .data_full, .ctrl_push, .ctrl_wdata, .ctrl_full
  );

  // Payload empty flag unused, a descriptor implies its whole frame is queued
  sync_fifo #(.WIDTH(WORD_W), .DEPTH(DATA_DEPTH)) data_fifo0 (
    .mac_clk, .app_rst, .push(data_push), .wdata(data_wdata), .full(data_full),
    .pop(data_pop), .rdata(data_rdata), .empty()
  );

  sync_fifo #(.WIDTH(WORD_W), .DEPTH(CTRL_DEPTH)) ctrl_fifo0 (
    .mac_clk, .app_rst, .push(ctrl_push), .wdata(ctrl_wdata.raw), .full(ctrl_full),
    .pop(ctrl_pop), .rdata(ctrl_rdata.raw), .empty(ctrl_empty)
  );

  arp_table arp0 (
    .mac_clk, .arp_addr, .arp_wr_en, .arp_wr_data, .arp_rd_data,
    .local_ip, .local_gateway, .dest_ip(ctrl_rdata.fields.dest_ip), .dest_mac
  );

  ip_header_calc #(.TTL(TTL)) hdr0 (
    .mac_clk, .app_rst, .load(hdr_load), .word_count(ctrl_rdata.fields.word_count),
    .dest_ip(ctrl_rdata.fields.dest_ip), .local_ip, .ip_length, .udp_length,
    .ip_checksum, .hdr_valid
  );

  udp_frame_tx #(.TTL(TTL)) framer0 (
    .mac_clk, .app_rst, .local_enable, .local_mac, .local_ip, .local_port,
    .ctrl_rdata, .ctrl_empty, .ctrl_pop, .data_rdata, .data_pop,
    .hdr_load, .hdr_valid, .ip_length, .udp_length, .ip_checksum, .dest_mac,
    .mac_tx_start, .mac_tx_ack, .mac_tx_data, .mac_tx_data_valid
  );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
  parameter int RST_CYCLES = 8
) (
  output logic mac_clk,
  output logic app_rst
);

  timeunit 1ns;
  timeprecision 100ps;

  initial mac_clk = 1'b0;
  always #5 mac_clk = ~mac_clk;  // 10 ns period

  initial begin
    app_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge mac_clk);
    app_rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* tb_udp_tx.sv */
`default_nettype none

module tb_udp_tx;

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [47:0] LOCAL_MAC  = 48'h02_11_22_33_44_55;
  localparam logic [31:0] LOCAL_IP   = 32'h0A_00_00_01;
  localparam logic [15:0] LOCAL_PORT = 16'hC350;
  localparam logic [7:0]  GATEWAY    = 8'hFE;
  localparam logic [7:0]  TTL        = 8'h40;
  localparam int NUM_FRAMES = 8;
  localparam int MAX_LEN    = 8;   // Payload words
  localparam int MAX_ACK    = 6;
  localparam int WATCHDOG_CYCLES =
    2 * 256 + NUM_FRAMES * (2 * (MAX_LEN + 6) + MAX_ACK + 20);

  logic        mac_clk;
  logic        app_rst;
  logic        local_enable;
  logic [7:0]  arp_addr;
  logic        arp_wr_en;
  logic [47:0] arp_wr_data;
  logic [47:0] arp_rd_data;
  logic        app_tx_valid;
  logic        app_tx_ready;
  logic [63:0] app_tx_data;
  logic        app_tx_end_of_frame;
  logic [31:0] app_tx_dest_ip;
  logic [15:0] app_tx_dest_port;
  logic        mac_tx_start;
  logic        mac_tx_ack;
  logic [63:0] mac_tx_data;
  logic [7:0]  mac_tx_data_valid;

  // Reference model state
  logic [47:0] arp_shadow [256];
  logic [31:0] fr_ip [16];
  logic [15:0] fr_port [16];
  int          fr_len [16];
  int          fr_base [16];
  logic [63:0] payload [256];
  logic [7:0]  exp_bytes [128];
  logic [7:0]  rx_bytes [128];
  int errors = 0;
  int frames_sent = 0;
  int frames_done = 0;
  int words_checked = 0;
  int pay_top = 0;
  int widx = 0;
  int rx_n = 0;
  logic prev_hold = 1'b0;

  tb_clk_gen #(.RST_CYCLES(8)) clk0 (.mac_clk, .app_rst);

  udp_tx_top #(.DATA_DEPTH(32), .CTRL_DEPTH(4), .TTL(TTL)) dut0 (
    .mac_clk, .app_rst, .local_enable, .local_mac(LOCAL_MAC), .local_ip(LOCAL_IP),
    .local_port(LOCAL_PORT), .local_gateway(GATEWAY), .arp_addr, .arp_wr_en,
    .arp_wr_data, .arp_rd_data, .app_tx_valid, .app_tx_ready, .app_tx_data,
    .app_tx_end_of_frame, .app_tx_dest_ip, .app_tx_dest_port, .mac_tx_start,
    .mac_tx_ack, .mac_tx_data, .mac_tx_data_valid
  );

  function automatic logic [47:0] arp_pattern(input logic [7:0] a);
    return {8'h02, a, ~a, a ^ 8'h5A, a + 8'h11, 8'h3C ^ {a[3:0], a[7:4]}};
  endfunction

  // Folded ones-complement sum of halfwords
  function automatic logic [15:0] fold16(input logic [31:0] s);
    logic [31:0] t;
    t = s;
    while (t[31:16] != 16'h0) t = 32'(t[15:0]) + 32'(t[31:16]);
    return t[15:0];
  endfunction

  function automatic logic [47:0] next_hop_mac(input logic [31:0] ip);
    if (ip[31:28] == 4'hE) return {24'h01005E, 1'b0, ip[22:0]};
    if (ip[31:8] == LOCAL_IP[31:8]) return arp_shadow[ip[7:0]];
    return arp_shadow[GATEWAY];
  endfunction

  // Wire bytes of frame f with the header first
  task automatic build_expected(input int f);
    logic [15:0] ip_len;
    logic [15:0] udp_len;
    logic [15:0] csum;
    logic [47:0] dmac;
    logic [31:0] s;
    logic [63:0] w;
    ip_len  = 16'(8 * fr_len[f] + 28);
    udp_len = 16'(8 * fr_len[f] + 8);
    dmac    = next_hop_mac(fr_ip[f]);
    s = 32'h4500 + 32'(ip_len) + 32'h4000 + 32'({TTL, 8'h11})
      + 32'(LOCAL_IP[31:16]) + 32'(LOCAL_IP[15:0])
      + 32'(fr_ip[f][31:16]) + 32'(fr_ip[f][15:0]);
    csum = ~fold16(s);
    for (int i = 0; i < 6; i++) begin
      exp_bytes[i]     = dmac[47-8*i -: 8];
      exp_bytes[6 + i] = LOCAL_MAC[47-8*i -: 8];
    end
    {exp_bytes[12], exp_bytes[13], exp_bytes[14], exp_bytes[15]} = 32'h0800_4500;
    {exp_bytes[16], exp_bytes[17], exp_bytes[18], exp_bytes[19]} = {ip_len, 16'h0000};
    {exp_bytes[20], exp_bytes[21], exp_bytes[22], exp_bytes[23]} = {16'h4000, TTL, 8'h11};
    {exp_bytes[24], exp_bytes[25]} = csum;
    for (int i = 0; i < 4; i++) begin
      exp_bytes[26 + i] = LOCAL_IP[31-8*i -: 8];
      exp_bytes[30 + i] = fr_ip[f][31-8*i -: 8];
    end
    {exp_bytes[34], exp_bytes[35], exp_bytes[36], exp_bytes[37]} = {LOCAL_PORT, fr_port[f]};
    {exp_bytes[38], exp_bytes[39], exp_bytes[40], exp_bytes[41]} = {udp_len, 16'h0000};
    for (int k = 0; k < fr_len[f]; k++) begin
      w = payload[fr_base[f] + k];
      for (int j = 0; j < 8; j++) exp_bytes[42 + 8*k + j] = w[63-8*j -: 8];
    end
  endtask

  // Checks the frame just received against its length rules and checksum
  task automatic check_rx_header(input int n);
    logic [31:0] s;
    s = 32'h0;
    for (int h = 0; h < 10; h++) s = s + 32'({rx_bytes[14 + 2*h], rx_bytes[15 + 2*h]});
    assert ({rx_bytes[16], rx_bytes[17]} == 16'(8 * n + 28)) else begin
      errors++;
      $display("Fail ip_length: got %h expected %h", {rx_bytes[16], rx_bytes[17]},
               16'(8 * n + 28));
    end
    assert ({rx_bytes[38], rx_bytes[39]} == 16'(8 * n + 8)) else begin
      errors++;
      $display("Fail udp_length: got %h expected %h", {rx_bytes[38], rx_bytes[39]},
               16'(8 * n + 8));
    end
    assert (fold16(s) == 16'hFFFF) else begin
      errors++;
      $display("Fail ip header sum: got %h expected ffff", fold16(s));
    end
  endtask

  // Caller sits just after a rising edge
  task automatic send_frame(input logic [31:0] ip, input logic [15:0] port, input int n);
    logic [63:0] d;
    fr_ip[frames_sent]   = ip;
    fr_port[frames_sent] = port;
    fr_len[frames_sent]  = n;
    fr_base[frames_sent] = pay_top;
    for (int w = 0; w < n; w++) begin
      d = {$urandom, $urandom};
      payload[pay_top + w] = d;
    end
    pay_top = pay_top + n;
    frames_sent++;
    for (int w = 0; w < n; w++) begin
      app_tx_valid        <= 1'b1;
      app_tx_data         <= payload[fr_base[frames_sent-1] + w];
      app_tx_end_of_frame <= (w == n - 1);
      app_tx_dest_ip      <= ip;
      app_tx_dest_port    <= port;
      @(negedge mac_clk);
      while (!app_tx_ready) @(negedge mac_clk);
      @(posedge mac_clk);  // Word taken on this edge
    end
    app_tx_valid        <= 1'b0;
    app_tx_end_of_frame <= 1'b0;
  endtask

  task automatic wait_all_frames;
    while (frames_done != frames_sent) @(posedge mac_clk);
  endtask

  // MAC model with a random ack delay
  initial begin
    int d;
    forever begin
      @(negedge mac_clk);
      if (mac_tx_start) begin
        d = $urandom_range(MAX_ACK, 0);
        repeat (d) @(posedge mac_clk);
        @(posedge mac_clk);
        mac_tx_ack <= 1'b1;
        @(posedge mac_clk);
        mac_tx_ack <= 1'b0;
      end
    end
  end

  always @(negedge mac_clk) begin : frame_monitor
    logic [7:0]  exp_valid;
    logic [63:0] exp_w;
    logic [63:0] mask;
    int n;
    if (!app_rst) begin
      if (prev_hold) begin
        assert (mac_tx_start) else begin
          errors++;
          $display("mac_tx_start dropped before ack");
        end
      end
      if (mac_tx_data_valid != 8'h00) begin
        assert (frames_done < frames_sent) else begin
          errors++;
          $display("Frame sent with no frame queued");
        end
        if (frames_done < frames_sent) begin
          n = fr_len[frames_done];
          if (widx == 0) build_expected(frames_done);
          exp_valid = (widx == n + 5) ? 8'h03 : 8'hFF;
          for (int i = 0; i < 8; i++) begin
            mask[8*i +: 8]  = {8{exp_valid[i]}};
            exp_w[8*i +: 8] = (8*widx + i < 42 + 8*n) ? exp_bytes[8*widx + i] : 8'h00;
          end
          assert (mac_tx_data_valid == exp_valid) else begin
            errors++;
            $display("Fail mac_tx_data_valid word %0d: got %h expected %h", widx,
                     mac_tx_data_valid, exp_valid);
          end
          assert ((mac_tx_data & mask) == exp_w) else begin
            errors++;
            $display("Fail mac_tx_data frame %0d word %0d: got %h expected %h",
                     frames_done, widx, mac_tx_data & mask, exp_w);
          end
          assert (mac_tx_start == (widx == 0)) else begin
            errors++;
            $display("Fail mac_tx_start word %0d: got %h expected %h", widx,
                     mac_tx_start, widx == 0);
          end
          if (!mac_tx_start || mac_tx_ack) begin  // Word moves on
            for (int i = 0; i < 8; i++) begin
              if (mac_tx_data_valid[i]) begin
                rx_bytes[rx_n] = mac_tx_data[8*i +: 8];
                rx_n++;
              end
            end
            words_checked++;
            widx++;
          end
          if (mac_tx_data_valid == 8'h03) begin
            check_rx_header(n);
            frames_done++;
            widx = 0;
            rx_n = 0;
          end
        end
      end else begin
        assert (widx == 0) else begin
          errors++;
          $display("Frame stopped before its last word");
        end
        widx = 0;
        rx_n = 0;
      end
      prev_hold = mac_tx_start && !mac_tx_ack;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("Timeout, frames did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $finish;
  end

  initial begin
    local_enable        = 1'b0;
    arp_addr            = 8'h00;
    arp_wr_en           = 1'b0;
    arp_wr_data         = 48'h0;
    app_tx_valid        = 1'b0;
    app_tx_data         = 64'h0;
    app_tx_end_of_frame = 1'b0;
    app_tx_dest_ip      = 32'h0;
    app_tx_dest_port    = 16'h0;
    mac_tx_ack          = 1'b0;
    void'($urandom(32'h3f5c));

    // Idle outputs once reset is gone
    @(negedge mac_clk);
    while (app_rst) @(negedge mac_clk);
    assert (mac_tx_start == 1'b0 && mac_tx_data_valid == 8'h00 && app_tx_ready) else begin
      errors++;
      $display("Fail idle outputs after reset: start %h valid %h ready %h",
               mac_tx_start, mac_tx_data_valid, app_tx_ready);
    end

    @(posedge mac_clk);
    for (int a = 0; a < 256; a++) begin
      arp_shadow[a] = arp_pattern(8'(a));
      arp_wr_en     <= 1'b1;
      arp_addr      <= 8'(a);
      arp_wr_data   <= arp_pattern(8'(a));
      @(posedge mac_clk);
    end
    arp_wr_en <= 1'b0;
    for (int i = 0; i < 2; i++) begin
      arp_addr <= (i == 0) ? 8'h17 : GATEWAY;
      @(posedge mac_clk);
      @(negedge mac_clk);
      assert (arp_rd_data == arp_shadow[arp_addr]) else begin
        errors++;
        $display("Fail arp_rd_data: got %h expected %h", arp_rd_data,
                 arp_shadow[arp_addr]);
      end
      @(posedge mac_clk);
    end

    local_enable <= 1'b1;
    send_frame(32'h0A00_0017, 16'h1234, 5);  // On subnet
    send_frame(32'h0A00_00C8, 16'h0050, 1);
    send_frame(32'hC0A8_0105, 16'h2000, 8);  // Through the gateway
    send_frame(32'hE12A_3344, 16'h3039, 3);  // Multicast
    wait_all_frames();

    // Fill the queues while the framer is held off
    local_enable <= 1'b0;
    send_frame(32'h0A00_0042, 16'h0101, 6);
    send_frame(32'hE07F_0001, 16'h0202, 6);
    send_frame(32'h0808_0808, 16'h0303, 6);
    send_frame(32'h0A00_00FF, 16'h0404, 6);
    @(negedge mac_clk);
    assert (!app_tx_ready) else begin
      errors++;
      $display("Fail app_tx_ready with full queues: got %h expected 0", app_tx_ready);
    end
    @(posedge mac_clk);
    local_enable <= 1'b1;
    wait_all_frames();
    repeat (4) @(posedge mac_clk);

    $display("Summary: %0d frames, %0d words checked, %0d errors",
             frames_done, words_checked, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
udp_tx_pkg.sv
sync_fifo.sv
udp_tx_ingress.sv
arp_table.sv
ip_header_calc.sv
udp_frame_tx.sv
udp_tx_top.sv
tb_clk_gen.sv
tb_udp_tx.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		--top-module udp_tx_top udp_tx_pkg.sv sync_fifo.sv udp_tx_ingress.sv \
		arp_table.sv ip_header_calc.sv udp_frame_tx.sv udp_tx_top.sv
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		--top-module tb_udp_tx -f tb.f

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_udp_tx -Mdir obj_dir -f tb.f
	./obj_dir/Vtb_udp_tx > sim.log 2>&1; cat sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
